// ==== core_wb.f ====
+incdir+verilog
verilog/core_wb_pkg.sv
verilog/wb_instr_queue.sv
verilog/wb_load_align.sv
verilog/wb_stage.sv
verilog/csr_file.sv
verilog/core_wb_top.sv
testbench/tb_clock_gen.sv
testbench/tb_checker.sv
testbench/core_wb_assertions.sv
testbench/tb_core_wb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the writeback testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_core_wb -f core_wb.f -o sim_core_wb

OUTPUT=$(./obj_dir/sim_core_wb)
echo "$OUTPUT"

if echo "$OUTPUT" | grep -q "Verification passed"; then
    exit 0
else
    exit 1
fi

// ==== testbench/tb_core_wb.sv ====
// Writeback subsystem testbench
// Table driven stimulus under credit control with reset and final report

`default_nettype none

`include "core_wb_params.svh"

module tb_core_wb import core_wb_pkg::*; ();

    localparam int MAX_ROWS = 40;

    logic             g_clk;
    logic             g_resetn;
    logic             in_valid;
    wb_instr_t        in_instr;
    logic             credit_return;
    wb_write_t        rd_write;
    trap_info_t       trap_out;
    logic             cf_valid;
    logic [`XLEN-1:0] cf_target;
    logic             trs_valid;
    logic [`XLEN-1:0] trs_pc;
    logic [`XLEN-1:0] trs_instr;
    wb_write_t        exp_write;
    logic [4:0]       exp_cause;
    logic             exp_cf;
    logic [`XLEN-1:0] exp_target;
    int               pass_count;
    int               fail_count;
    int               done_count;

    wb_instr_t        row_instr [MAX_ROWS];
    wb_write_t        row_write [MAX_ROWS];
    logic [4:0]       row_cause [MAX_ROWS];   // Zero means no trap
    logic             row_cf [MAX_ROWS];
    logic [31:0]      row_target [MAX_ROWS];
    int               num_rows;
    int               burst_start;
    int               sent;
    int               returned;
    int               errors;
    int               seed;

    tb_clock_gen u_clk (.g_clk(g_clk));

    core_wb_top uut (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .in_valid      (in_valid),
        .in_instr      (in_instr),
        .credit_return (credit_return),
        .rd_write      (rd_write),
        .trap_out      (trap_out),
        .cf_valid      (cf_valid),
        .cf_target     (cf_target),
        .trs_valid     (trs_valid),
        .trs_pc        (trs_pc),
        .trs_instr     (trs_instr)
    );

    tb_checker u_chk (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .in_valid   (in_valid),
        .in_instr   (in_instr),
        .exp_write  (exp_write),
        .exp_cause  (exp_cause),
        .exp_cf     (exp_cf),
        .exp_target (exp_target),
        .rd_write   (rd_write),
        .trap_out   (trap_out),
        .cf_valid   (cf_valid),
        .cf_target  (cf_target),
        .trs_valid  (trs_valid),
        .trs_pc     (trs_pc),
        .trs_instr  (trs_instr),
        .pass_count (pass_count),
        .fail_count (fail_count),
        .done_count (done_count)
    );

    // Credits come back mid cycle
    always @(negedge g_clk) begin
        if (g_resetn && credit_return) begin
            returned = returned + 1;
        end
    end

    // ----------------------------------------
    // Micro-op builders

    function automatic uop_u lsu_uop(input logic ld, input logic st, input lsu_size_e sz);
        uop_u u;
        u.lsu.load  = ld;
        u.lsu.store = st;
        u.lsu.size  = sz;
        return u;
    endfunction

    function automatic uop_u csr_uop(input logic r, input logic w, input logic s,
                                     input logic c);
        uop_u u;
        u.csr.rd  = r;
        u.csr.wr  = w;
        u.csr.set = s;
        u.csr.clr = c;
        return u;
    endfunction

    task automatic add_row(input logic [31:0] pc, input wb_op_e op, input cfu_op_e cfu,
                           input uop_u uop, input logic [31:0] result,
                           input logic [31:0] ld_data, input logic [4:0] rd,
                           input logic [11:0] addr, input logic merr, input logic trap,
                           input logic [4:0] tcause, input logic wen,
                           input logic [31:0] wdata, input logic [4:0] cause,
                           input logic cf, input logic [31:0] target);
        wb_instr_t t;
        t = '0;
        t.pc         = pc;
        t.n_pc       = pc + 32'd4;
        t.instr      = {pc[15:0], 16'h0073};
        t.result     = result;
        t.load_data  = ld_data;
        t.rd         = rd;
        t.wb_op      = op;
        t.cfu_op     = cfu;
        t.uop        = uop;
        t.csr_addr   = addr;
        t.mem_err    = merr;
        t.trap       = trap;
        t.trap_cause = tcause;
        row_instr[num_rows]  = t;
        row_write[num_rows]  = '{wen: wen, addr: rd, wdata: wdata};
        row_cause[num_rows]  = cause;
        row_cf[num_rows]     = cf;
        row_target[num_rows] = target;
        num_rows = num_rows + 1;
    endtask

    // ----------------------------------------
    // Stimulus table with offline expected values

    task automatic build_table();
        uop_u nop;
        uop_u rd_only;
        int   k;
        nop     = '0;
        rd_only = csr_uop(1, 0, 0, 0);
        // Result writeback, then x0 suppressed
        add_row(32'h100, WB_RESULT, CFU_NONE, nop, 32'h1234_5678, 0, 5, 0, 0, 0, 0,
                1, 32'h1234_5678, 0, 0, 0);
        add_row(32'h104, WB_RESULT, CFU_NONE, nop, 32'h0000_dead, 0, 0, 0, 0, 0, 0,
                0, 0, 0, 0, 0);
        // Loads from word f0e182c3
        add_row(32'h108, WB_LOAD, CFU_NONE, lsu_uop(1, 0, SIZE_BYTE), 32'h2000,
                32'hf0e1_82c3, 1, 0, 0, 0, 0, 1, 32'hffff_ffc3, 0, 0, 0);
        add_row(32'h10c, WB_LOAD, CFU_NONE, lsu_uop(1, 0, SIZE_BYTE), 32'h2002,
                32'hf0e1_82c3, 2, 0, 0, 0, 0, 1, 32'hffff_ffe1, 0, 0, 0);
        add_row(32'h110, WB_LOAD, CFU_NONE, lsu_uop(1, 0, SIZE_BYTEU), 32'h2001,
                32'hf0e1_82c3, 3, 0, 0, 0, 0, 1, 32'h0000_0082, 0, 0, 0);
        add_row(32'h114, WB_LOAD, CFU_NONE, lsu_uop(1, 0, SIZE_BYTEU), 32'h2003,
                32'hf0e1_82c3, 4, 0, 0, 0, 0, 1, 32'h0000_00f0, 0, 0, 0);
        add_row(32'h118, WB_LOAD, CFU_NONE, lsu_uop(1, 0, SIZE_HALF), 32'h2000,
                32'hf0e1_82c3, 5, 0, 0, 0, 0, 1, 32'hffff_82c3, 0, 0, 0);
        add_row(32'h11c, WB_LOAD, CFU_NONE, lsu_uop(1, 0, SIZE_HALF), 32'h2002,
                32'hf0e1_82c3, 6, 0, 0, 0, 0, 1, 32'hffff_f0e1, 0, 0, 0);
        add_row(32'h120, WB_LOAD, CFU_NONE, lsu_uop(1, 0, SIZE_WORD), 32'h2000,
                32'hf0e1_82c3, 7, 0, 0, 0, 0, 1, 32'hf0e1_82c3, 0, 0, 0);
        add_row(32'h124, WB_LOAD, CFU_NONE, lsu_uop(1, 0, SIZE_HALF), 32'h2000,
                32'h1234_7fff, 8, 0, 0, 0, 0, 1, 32'h0000_7fff, 0, 0, 0);
        // mscratch access, old value returned
        add_row(32'h128, WB_CSR, CFU_NONE, csr_uop(1, 1, 0, 0), 32'ha5a5_0000, 0, 6,
                `CSR_MSCRATCH, 0, 0, 0, 1, 32'h0, 0, 0, 0);
        add_row(32'h12c, WB_CSR, CFU_NONE, rd_only, 0, 0, 9,
                `CSR_MSCRATCH, 0, 0, 0, 1, 32'ha5a5_0000, 0, 0, 0);
        add_row(32'h130, WB_CSR, CFU_NONE, csr_uop(1, 0, 1, 0), 32'h0000_00ff, 0, 7,
                `CSR_MSCRATCH, 0, 0, 0, 1, 32'ha5a5_0000, 0, 0, 0);
        add_row(32'h134, WB_CSR, CFU_NONE, csr_uop(1, 0, 0, 1), 32'ha000_0000, 0, 8,
                `CSR_MSCRATCH, 0, 0, 0, 1, 32'ha5a5_00ff, 0, 0, 0);
        add_row(32'h138, WB_CSR, CFU_NONE, rd_only, 0, 0, 9,
                `CSR_MSCRATCH, 0, 0, 0, 1, 32'h05a5_00ff, 0, 0, 0);
        // Unknown CSR traps to mtvec zero
        add_row(32'h140, WB_CSR, CFU_NONE, csr_uop(1, 1, 0, 0), 32'h1234, 0, 10,
                12'h7c0, 0, 0, 0, 0, 0, `CAUSE_IOPCODE, 1, 32'h0);
        add_row(32'h144, WB_CSR, CFU_NONE, rd_only, 0, 0, 9,
                `CSR_MSCRATCH, 0, 0, 0, 1, 32'h05a5_00ff, 0, 0, 0);
        // Program mtvec, check mcause from the illegal access
        add_row(32'h148, WB_CSR, CFU_NONE, csr_uop(1, 1, 0, 0), 32'h8000_0000, 0, 11,
                `CSR_MTVEC, 0, 0, 0, 1, 32'h0, 0, 0, 0);
        add_row(32'h14c, WB_CSR, CFU_NONE, rd_only, 0, 0, 12,
                `CSR_MCAUSE, 0, 0, 0, 1, 32'h2, 0, 0, 0);
        // Explicit, load and store traps
        add_row(32'h200, WB_RESULT, CFU_TRAP, nop, 32'h55, 0, 3, 0, 0, 1, 5'd11,
                0, 0, 5'd11, 1, 32'h8000_0000);
        add_row(32'h204, WB_CSR, CFU_NONE, rd_only, 0, 0, 13,
                `CSR_MEPC, 0, 0, 0, 1, 32'h200, 0, 0, 0);
        add_row(32'h208, WB_LOAD, CFU_NONE, lsu_uop(1, 0, SIZE_WORD), 32'h3000,
                32'h1111_1111, 14, 0, 1, 0, 0, 0, 0, `CAUSE_LDACCESS, 1, 32'h8000_0000);
        add_row(32'h20c, WB_CSR, CFU_NONE, rd_only, 0, 0, 13,
                `CSR_MEPC, 0, 0, 0, 1, 32'h208, 0, 0, 0);
        add_row(32'h210, WB_NONE, CFU_NONE, lsu_uop(0, 1, SIZE_WORD), 32'h3004,
                0, 0, 0, 1, 0, 0, 0, 0, `CAUSE_STACCESS, 1, 32'h8000_0000);
        add_row(32'h214, WB_CSR, CFU_NONE, rd_only, 0, 0, 13,
                `CSR_MEPC, 0, 0, 0, 1, 32'h210, 0, 0, 0);
        add_row(32'h218, WB_CSR, CFU_NONE, rd_only, 0, 0, 12,
                `CSR_MCAUSE, 0, 0, 0, 1, 32'h7, 0, 0, 0);
        // MRET back to mepc
        add_row(32'h220, WB_NONE, CFU_MRET, nop, 0, 0, 0, 0, 0, 0, 0,
                0, 0, 0, 1, 32'h210);
        // Back to back burst
        burst_start = num_rows;
        for (k = 0; k < 6; k++) begin
            add_row(32'h300 + 32'(4 * k), WB_RESULT, CFU_NONE, nop, 32'h0bad_0000 + 32'(k),
                    0, 5'(16 + k), 0, 0, 0, 0, 1, 32'h0bad_0000 + 32'(k), 0, 0, 0);
        end
    endtask

    // ----------------------------------------
    // Main sequence

    initial begin
        int i;
        int gap;
        int waited;
        g_resetn   = 1'b0;
        in_valid   = 1'b0;
        in_instr   = '0;
        exp_write  = '0;
        exp_cause  = '0;
        exp_cf     = 1'b0;
        exp_target = '0;
        num_rows   = 0;
        sent       = 0;
        returned   = 0;
        errors     = 0;
        seed       = 12;
        build_table();
        repeat (16) @(posedge g_clk);
        #1 g_resetn = 1'b1;
        for (i = 0; i < num_rows; i++) begin
            gap = (i < burst_start) ? int'($unsigned($random(seed)) % 3) : 0;
            repeat (gap) begin
                @(posedge g_clk);
                #1 in_valid = 1'b0;
            end
            waited = 0;
            while (`WB_QUEUE_DEPTH - sent + returned <= 0 && waited < 100) begin
                @(posedge g_clk);
                #1 in_valid = 1'b0;
                waited = waited + 1;
            end
            if (waited >= 100) begin
                $display("Timed out waiting for a credit at row %0d", i);
                errors = errors + 1;
                break;
            end
            in_valid   = 1'b1;
            in_instr   = row_instr[i];
            exp_write  = row_write[i];
            exp_cause  = row_cause[i];
            exp_cf     = row_cf[i];
            exp_target = row_target[i];
            sent = sent + 1;
            @(posedge g_clk);
            #1 in_valid = 1'b0;
        end
        waited = 0;
        while ((done_count < sent || returned < sent) && waited < 200) begin
            @(posedge g_clk);
            waited = waited + 1;
        end
        if (waited >= 200) begin
            $display("Timed out waiting for %0d retirements and credits", sent);
            errors = errors + 1;
        end
        if (sent != num_rows) begin
            $display("Only %0d of %0d rows were sent", sent, num_rows);
            errors = errors + 1;
        end
        $display("Tests passed %0d, failed %0d, other errors %0d",
                 pass_count, fail_count, errors);
        if (fail_count == 0 && errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/core_wb_assertions.sv ====
// Writeback protocol assertions
// Credit use, credit return and trap output consistency

`default_nettype none

`include "core_wb_params.svh"

module core_wb_assertions import core_wb_pkg::*; (
    input logic       g_clk,
    input logic       g_resetn,
    input logic       in_valid,
    input logic       credit_return,
    input logic       trs_valid,
    input wb_write_t  rd_write,
    input trap_info_t trap_out,
    input logic       cf_valid
);

    int credits;                    // Credits held by the sender

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            credits <= `WB_QUEUE_DEPTH;
        end else begin
            credits <= credits - int'(in_valid) + int'(credit_return);
        end
    end

    a_credit_held: assert property (@(posedge g_clk) disable iff (!g_resetn)
        in_valid |-> credits > 0)
        else $error("in_valid without a credit");

    a_credit_retire: assert property (@(posedge g_clk) disable iff (!g_resetn)
        credit_return == trs_valid)
        else $error("credit_return differs from trs_valid");

    a_no_trap_write: assert property (@(posedge g_clk) disable iff (!g_resetn)
        !(rd_write.wen && trap_out.valid))
        else $error("rd write on a trapping instruction");

    a_trap_redirect: assert property (@(posedge g_clk) disable iff (!g_resetn)
        trap_out.valid |-> cf_valid)
        else $error("trap without control flow redirect");

endmodule

bind core_wb_top core_wb_assertions u_assert (
    .g_clk         (g_clk),
    .g_resetn      (g_resetn),
    .in_valid      (in_valid),
    .credit_return (credit_return),
    .trs_valid     (trs_valid),
    .rd_write      (rd_write),
    .trap_out      (trap_out),
    .cf_valid      (cf_valid)
);

`default_nettype wire

// ==== testbench/tb_checker.sv ====
// Writeback result checker
// Queues expected rows as they are sent and compares them at each retirement

`default_nettype none

`include "core_wb_params.svh"

module tb_checker import core_wb_pkg::*; (
    input  logic             g_clk,
    input  logic             g_resetn,
    input  logic             in_valid,
    input  wb_instr_t        in_instr,
    input  wb_write_t        exp_write,
    input  logic [4:0]       exp_cause,     // Zero means no trap
    input  logic             exp_cf,
    input  logic [`XLEN-1:0] exp_target,
    input  wb_write_t        rd_write,
    input  trap_info_t       trap_out,
    input  logic             cf_valid,
    input  logic [`XLEN-1:0] cf_target,
    input  logic             trs_valid,
    input  logic [`XLEN-1:0] trs_pc,
    input  logic [`XLEN-1:0] trs_instr,
    output int               pass_count,
    output int               fail_count,
    output int               done_count
);

    wb_write_t        q_write [$];
    logic [4:0]       q_cause [$];
    logic             q_cf [$];
    logic [`XLEN-1:0] q_target [$];
    logic [`XLEN-1:0] q_pc [$];
    logic [`XLEN-1:0] q_instr [$];

    initial begin
        pass_count = 0;
        fail_count = 0;
        done_count = 0;
    end

    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] exp, inout bit ok);
        if (got !== exp) begin
            $display("FAILED time %0t %s got %h expected %h", $time, name, got, exp);
            ok = 1'b0;
        end
    endtask

    // ----------------------------------------
    // Expected rows enter with the instruction
    always @(posedge g_clk) begin
        if (g_resetn && in_valid) begin
            q_write.push_back(exp_write);
            q_cause.push_back(exp_cause);
            q_cf.push_back(exp_cf);
            q_target.push_back(exp_target);
            q_pc.push_back(in_instr.pc);
            q_instr.push_back(in_instr.instr);
        end
    end

    // ----------------------------------------
    // Mid cycle compare, outputs are settled here
    always @(negedge g_clk) begin
        wb_write_t        w;
        logic [4:0]       c;
        logic [`XLEN-1:0] p;
        bit               ok;
        if (g_resetn && trs_valid) begin
            if (q_pc.size() == 0) begin
                $display("An instruction retired at time %0t with nothing expected", $time);
                fail_count = fail_count + 1;
            end else begin
                ok = 1'b1;
                w  = q_write.pop_front();
                c  = q_cause.pop_front();
                p  = q_pc.pop_front();
                compare("trs_pc", trs_pc, p, ok);
                compare("trs_instr", trs_instr, q_instr.pop_front(), ok);
                compare("rd_write.wen", 32'(rd_write.wen), 32'(w.wen), ok);
                if (w.wen) begin
                    compare("rd_write.addr", 32'(rd_write.addr), 32'(w.addr), ok);
                    compare("rd_write.wdata", rd_write.wdata, w.wdata, ok);
                end
                compare("trap_out.valid", 32'(trap_out.valid), 32'(c != 5'd0), ok);
                if (c != 5'd0) begin
                    compare("trap_out.cause", 32'(trap_out.cause), 32'(c), ok);
                    compare("trap_out.pc", trap_out.pc, p, ok);
                end
                compare("cf_valid", 32'(cf_valid), 32'(q_cf[0]), ok);
                if (q_cf[0]) begin
                    compare("cf_target", cf_target, q_target[0], ok);
                end
                void'(q_cf.pop_front());
                void'(q_target.pop_front());
                if (ok) begin
                    $display("Test %0d pc %h passed", done_count, trs_pc);
                    pass_count = pass_count + 1;
                end else begin
                    $display("Test %0d pc %h failed", done_count, trs_pc);
                    fail_count = fail_count + 1;
                end
                done_count = done_count + 1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
// Testbench clock source
// Free running clock with a period of 4

`default_nettype none

module tb_clock_gen (
    output logic g_clk
);

    initial begin
        g_clk = 1'b0;
    end

    always #2 g_clk = ~g_clk;       // Half period

endmodule

`default_nettype wire

// ==== verilog/core_wb_top.sv ====
// Writeback subsystem top
// Instruction queue, writeback stage and CSR file

`default_nettype none

`include "core_wb_params.svh"

module core_wb_top import core_wb_pkg::*; (
    input  logic             g_clk,
    input  logic             g_resetn,
    input  logic             in_valid,
    input  wb_instr_t        in_instr,
    output logic             credit_return,
    output wb_write_t        rd_write,
    output trap_info_t       trap_out,
    output logic             cf_valid,
    output logic [`XLEN-1:0] cf_target,
    output logic             trs_valid,
    output logic [`XLEN-1:0] trs_pc,
    output logic [`XLEN-1:0] trs_instr
);

    logic             head_valid;
    wb_instr_t        head_instr;
    logic             head_pop;
    csr_req_t         csr_req;
    logic [`XLEN-1:0] csr_rdata;
    logic             csr_error;
    logic [`XLEN-1:0] mtvec;
    logic [`XLEN-1:0] mepc;

    wb_instr_queue u_queue (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .in_valid      (in_valid),
        .in_instr      (in_instr),
        .head_pop      (head_pop),
        .head_valid    (head_valid),
        .head_instr    (head_instr),
        .credit_return (credit_return)
    );

    wb_stage u_stage (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .head_valid (head_valid),
        .head_instr (head_instr),
        .csr_rdata  (csr_rdata),
        .csr_error  (csr_error),
        .mtvec      (mtvec),
        .mepc       (mepc),
        .head_pop   (head_pop),
        .csr_req    (csr_req),
        .trap_req   (trap_out),         // Also the trap capture request
        .rd_write   (rd_write),
        .cf_valid   (cf_valid),
        .cf_target  (cf_target),
        .trs_valid  (trs_valid),
        .trs_pc     (trs_pc),
        .trs_instr  (trs_instr)
    );

    csr_file u_csr (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .csr_req   (csr_req),
        .trap_req  (trap_out),
        .csr_rdata (csr_rdata),
        .csr_error (csr_error),
        .mtvec     (mtvec),
        .mepc      (mepc)
    );

endmodule

`default_nettype wire

// ==== verilog/csr_file.sv ====
// Machine mode CSR file
// Address decode, read-modify-write access and trap state capture

`default_nettype none

`include "core_wb_params.svh"

module csr_file import core_wb_pkg::*; (
    input  logic             g_clk,
    input  logic             g_resetn,
    input  csr_req_t         csr_req,
    input  trap_info_t       trap_req,
    output logic [`XLEN-1:0] csr_rdata,
    output logic             csr_error,
    output logic [`XLEN-1:0] mtvec,
    output logic [`XLEN-1:0] mepc
);

    logic [`XLEN-1:0] mcause;
    logic [`XLEN-1:0] mscratch;
    logic             sel_mtvec;
    logic             sel_mepc;
    logic             sel_mcause;
    logic             sel_mscratch;
    logic             known;
    logic [`XLEN-1:0] new_value;
    logic             do_write;

    // ----------------------------------------
    // Address decode and read

    assign sel_mtvec    = csr_req.addr == `CSR_MTVEC;
    assign sel_mepc     = csr_req.addr == `CSR_MEPC;
    assign sel_mcause   = csr_req.addr == `CSR_MCAUSE;
    assign sel_mscratch = csr_req.addr == `CSR_MSCRATCH;
    assign known        = sel_mtvec || sel_mepc || sel_mcause || sel_mscratch;

    assign csr_error = csr_req.en && !known;

    always_comb begin
        csr_rdata = '0;
        if (sel_mtvec)    csr_rdata = mtvec;
        if (sel_mepc)     csr_rdata = mepc;
        if (sel_mcause)   csr_rdata = mcause;
        if (sel_mscratch) csr_rdata = mscratch;
    end

    // Write data, set and clear act on the old value
    always_comb begin
        if (csr_req.wr) begin
            new_value = csr_req.wdata;
        end else if (csr_req.set) begin
            new_value = csr_rdata | csr_req.wdata;
        end else begin
            new_value = csr_rdata & ~csr_req.wdata;
        end
    end

    assign do_write = csr_req.en && known && !trap_req.valid &&
                      (csr_req.wr || csr_req.set || csr_req.clr);

    // ----------------------------------------
    // State update

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mtvec    <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mscratch <= '0;
        end else begin
            if (do_write) begin
                if (sel_mtvec)    mtvec    <= new_value;
                if (sel_mepc)     mepc     <= new_value;
                if (sel_mcause)   mcause   <= new_value;
                if (sel_mscratch) mscratch <= new_value;
            end
            if (trap_req.valid) begin   // Capture wins over any access
                mepc   <= trap_req.pc;
                mcause <= {{(`XLEN - `CAUSE_W){1'b0}}, trap_req.cause};
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/wb_stage.sv ====
// Writeback stage
// Retires the queue head, builds CSR and trap requests, drives rd and trace

`default_nettype none

`include "core_wb_params.svh"

module wb_stage import core_wb_pkg::*; (
    input  logic             g_clk,
    input  logic             g_resetn,
    input  logic             head_valid,
    input  wb_instr_t        head_instr,
    input  logic [`XLEN-1:0] csr_rdata,
    input  logic             csr_error,
    input  logic [`XLEN-1:0] mtvec,
    input  logic [`XLEN-1:0] mepc,
    output logic             head_pop,
    output csr_req_t         csr_req,
    output trap_info_t       trap_req,
    output wb_write_t        rd_write,
    output logic             cf_valid,
    output logic [`XLEN-1:0] cf_target,
    output logic             trs_valid,
    output logic [`XLEN-1:0] trs_pc,
    output logic [`XLEN-1:0] trs_instr
);

    logic                retire;
    logic                use_csr;
    lsu_ctrl_t           lsu;
    csr_ctrl_t           csr;
    logic                csr_any;
    logic [`XLEN-1:0]    load_value;
    logic                trap_explicit;
    logic                trap_load;
    logic                trap_store;
    logic                trap_any;
    logic [`CAUSE_W-1:0] cause;
    logic                mret;

    // No stall, the head always retires
    assign retire   = head_valid;
    assign head_pop = retire;

    // ----------------------------------------
    // Micro-op decode

    assign use_csr = head_instr.wb_op == WB_CSR;
    assign lsu     = use_csr ? '0 : head_instr.uop.lsu;
    assign csr     = use_csr ? head_instr.uop.csr : '0;
    assign csr_any = csr.rd || csr.wr || csr.set || csr.clr;

    wb_load_align u_align (
        .load_data (head_instr.load_data),
        .offset    (head_instr.result[1:0]),
        .ctrl      (lsu),
        .aligned   (load_value)
    );

    // ----------------------------------------
    // CSR access

    always_comb begin
        csr_req.en    = retire && csr_any && !trap_explicit;
        csr_req.wr    = csr.wr;
        csr_req.set   = csr.set;
        csr_req.clr   = csr.clr;
        csr_req.addr  = head_instr.csr_addr;
        csr_req.wdata = head_instr.result;  // Operand for write, set, clear
    end

    // ----------------------------------------
    // Traps, highest priority first

    assign trap_explicit = head_instr.trap || head_instr.cfu_op == CFU_TRAP;
    assign trap_load     = lsu.load  && head_instr.mem_err;
    assign trap_store    = lsu.store && head_instr.mem_err;
    assign trap_any      = retire && (trap_explicit || trap_load || trap_store || csr_error);

    always_comb begin
        if (trap_explicit) begin
            cause = head_instr.trap_cause;  // Cause carried in the packet
        end else if (trap_load) begin
            cause = `CAUSE_LDACCESS;
        end else if (trap_store) begin
            cause = `CAUSE_STACCESS;
        end else begin
            cause = `CAUSE_IOPCODE;
        end
    end

    assign trap_req.valid = trap_any;
    assign trap_req.cause = cause;
    assign trap_req.pc    = head_instr.pc;

    // ----------------------------------------
    // Register writeback

    always_comb begin
        case (head_instr.wb_op)
            WB_RESULT: rd_write.wdata = head_instr.result;
            WB_LOAD:   rd_write.wdata = load_value;
            WB_CSR:    rd_write.wdata = csr_rdata;
            default:   rd_write.wdata = '0;
        endcase
    end

    assign rd_write.addr = head_instr.rd;
    assign rd_write.wen  = retire && head_instr.wb_op != WB_NONE &&
                           head_instr.rd != 5'd0 && !trap_any;   // x0 stays zero

    // ----------------------------------------
    // Control flow and trace

    assign mret      = retire && head_instr.cfu_op == CFU_MRET;
    assign cf_valid  = trap_any || mret;
    assign cf_target = trap_any ? mtvec : mepc;

    assign trs_valid = retire;
    assign trs_pc    = head_instr.pc;
    assign trs_instr = head_instr.instr;

endmodule

`default_nettype wire

// ==== verilog/wb_load_align.sv ====
// Load data alignment
// Shifts the memory word to the access offset, then masks and extends

`default_nettype none

`include "core_wb_params.svh"

module wb_load_align import core_wb_pkg::*; (
    input  logic [`XLEN-1:0] load_data,
    input  logic [1:0]       offset,        // Low address bits
    input  lsu_ctrl_t        ctrl,
    output logic [`XLEN-1:0] aligned
);

    logic [`XLEN-1:0] shifted;

    assign shifted = load_data >> {offset, 3'b000};

    always_comb begin
        case (ctrl.size)
            SIZE_BYTE: begin
                aligned = {{(`XLEN - 8){shifted[7]}}, shifted[7:0]};
            end
            SIZE_BYTEU: begin
                aligned = {{(`XLEN - 8){1'b0}}, shifted[7:0]};
            end
            SIZE_HALF: begin
                aligned = {{(`XLEN - 16){shifted[15]}}, shifted[15:0]};
            end
            default: begin
                aligned = shifted;          // Full word
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/wb_instr_queue.sv ====
// Writeback instruction queue
// Circular buffer fed under credit control, a pop hands one credit back

`default_nettype none

`include "core_wb_params.svh"

module wb_instr_queue import core_wb_pkg::*; (
    input  logic      g_clk,
    input  logic      g_resetn,
    input  logic      in_valid,             // Sender holds a credit
    input  wb_instr_t in_instr,
    input  logic      head_pop,             // Head retired this cycle
    output logic      head_valid,
    output wb_instr_t head_instr,
    output logic      credit_return
);

    localparam int PTR_W = $clog2(`WB_QUEUE_DEPTH);
    localparam int CNT_W = $clog2(`WB_QUEUE_DEPTH + 1);

    wb_instr_t        entries [`WB_QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             pop;

    assign head_valid    = count != '0;
    assign head_instr    = entries[rd_ptr];
    assign pop           = head_pop && head_valid;
    assign credit_return = pop;             // Freed slot goes back as a credit

    // ----------------------------------------
    // Storage

    always_ff @(posedge g_clk) begin
        if (in_valid) begin
            entries[wr_ptr] <= in_instr;
        end
    end

    // ----------------------------------------
    // Pointers and occupancy

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (in_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(`WB_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`WB_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(in_valid) - CNT_W'(pop);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/core_wb_pkg.sv ====
// Writeback subsystem types
// Operation encodings, micro-op union and the packets passed between blocks

`default_nettype none

`include "core_wb_params.svh"

package core_wb_pkg;

    typedef enum logic [1:0] {
        WB_NONE   = 2'd0,           // No register write
        WB_RESULT = 2'd1,           // ALU result
        WB_LOAD   = 2'd2,           // Aligned load data
        WB_CSR    = 2'd3            // CSR read data
    } wb_op_e;

    typedef enum logic [1:0] {
        CFU_NONE = 2'd0,
        CFU_TRAP = 2'd1,
        CFU_MRET = 2'd2
    } cfu_op_e;

    // Sign extension is folded into the size code
    typedef enum logic [1:0] {
        SIZE_BYTE  = 2'd0,          // Byte, sign extended
        SIZE_BYTEU = 2'd1,          // Byte, zero extended
        SIZE_HALF  = 2'd2,          // Half, sign extended
        SIZE_WORD  = 2'd3
    } lsu_size_e;

    typedef struct packed {
        logic      load;
        logic      store;
        lsu_size_e size;
    } lsu_ctrl_t;

    typedef struct packed {
        logic rd;
        logic wr;
        logic set;
        logic clr;
    } csr_ctrl_t;

    // Reading selected by wb_op, CSR controls only for WB_CSR
    typedef union packed {
        lsu_ctrl_t lsu;
        csr_ctrl_t csr;
    } uop_u;

    typedef struct packed {
        logic [`XLEN-1:0]   pc;
        logic [`XLEN-1:0]   n_pc;
        logic [31:0]        instr;
        logic [`XLEN-1:0]   result;         // ALU result, address or CSR wdata
        logic [`XLEN-1:0]   load_data;      // Raw memory word
        logic [4:0]         rd;
        wb_op_e             wb_op;
        cfu_op_e            cfu_op;
        uop_u               uop;
        logic [11:0]        csr_addr;
        logic               mem_err;        // Load or store access error
        logic               trap;
        logic [`CAUSE_W-1:0] trap_cause;
    } wb_instr_t;

    typedef struct packed {
        logic               wen;
        logic [4:0]         addr;
        logic [`XLEN-1:0]   wdata;
    } wb_write_t;

    typedef struct packed {
        logic                valid;
        logic [`CAUSE_W-1:0] cause;
        logic [`XLEN-1:0]    pc;
    } trap_info_t;

    typedef struct packed {
        logic               en;
        logic               wr;
        logic               set;
        logic               clr;
        logic [11:0]        addr;
        logic [`XLEN-1:0]   wdata;
    } csr_req_t;

endpackage

`default_nettype wire

// ==== verilog/core_wb_params.svh ====
// Writeback subsystem parameters
// Data width, queue depth, CSR addresses and trap causes

`ifndef CORE_WB_PARAMS_SVH
`define CORE_WB_PARAMS_SVH

// ----------------------------------------
// Widths and sizes

`define XLEN            32          // Data word width
`define WB_QUEUE_DEPTH  4           // Queue entries and initial credits
`define CAUSE_W         5           // Trap cause code width

// ----------------------------------------
// Machine mode CSR addresses

`define CSR_MTVEC       12'h305
`define CSR_MSCRATCH    12'h340
`define CSR_MEPC        12'h341
`define CSR_MCAUSE      12'h342

// ----------------------------------------
// Trap cause codes

`define CAUSE_IOPCODE   5'd2        // Illegal instruction
`define CAUSE_LDACCESS  5'd5        // Load access fault
`define CAUSE_STACCESS  5'd7        // Store access fault

`endif
